/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_id_stage
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' files.f)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f files.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
    input  logic                       ds_valid,
    input  logic                       flush,
    input  logic                       blocked,
    input  logic [id_pkg::xlen-1:0]    ds_pc,
    input  logic [15:0]                imm,
    input  logic [25:0]                jidx,
    input  logic [id_pkg::br_op_w-1:0] branch_op,
    input  logic                       jump_j,
    input  logic                       jump_jal,
    input  logic                       jump_jr,
    input  logic [id_pkg::xlen-1:0]    rs_value,
    input  logic [id_pkg::xlen-1:0]    rt_value,
    output logic                       br_or_jump,
    output logic                       br_stall,
    output logic                       br_taken,
    output logic [id_pkg::xlen-1:0]    br_target
);
    import id_pkg::*;

    logic [xlen-1:0] slot_pc;
    logic            is_branch;
    logic            rs_eq_rt;
    logic            rs_ltz;
    logic            rs_gtz;
    logic            cond;

    // delay slot address
    assign slot_pc   = ds_pc + 32'd4;
    assign is_branch = |branch_op;

    assign rs_eq_rt = (rs_value == rt_value);
    assign rs_ltz   = rs_value[xlen-1];
    assign rs_gtz   = !rs_value[xlen-1] && (|rs_value);

    assign cond = (branch_op[br_beq]  &&  rs_eq_rt) ||
                  (branch_op[br_bne]  && !rs_eq_rt) ||
                  (branch_op[br_bgez] && !rs_ltz)   ||
                  (branch_op[br_bgtz] &&  rs_gtz)   ||
                  (branch_op[br_blez] && !rs_gtz)   ||
                  (branch_op[br_bltz] &&  rs_ltz)   ||
                  jump_j || jump_jal || jump_jr;

    assign br_or_jump = ds_valid && (is_branch || jump_j || jump_jal || jump_jr);
    assign br_taken   = ds_valid && cond && !flush;
    // fetch must wait for the real operand
    assign br_stall   = ds_valid && blocked && (is_branch || jump_jr) && !flush;

    assign br_target = is_branch          ? slot_pc + {{14{imm[15]}}, imm, 2'b00} :
                       jump_jr            ? rs_value :
                       (jump_j||jump_jal) ? {slot_pc[31:28], jidx, 2'b00} :
                                            '0;

endmodule

`default_nettype wire

/* decode_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_ctrl (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          fs_to_ds_valid,
    input  id_pkg::inst_t                 fs_inst,
    input  logic [id_pkg::xlen-1:0]       fs_pc,
    input  logic                          es_allowin,
    input  logic                          flush,
    input  logic                          rs_used,
    input  logic                          rt_used,
    input  logic                          es_fwd_valid,
    input  logic                          es_load,
    input  logic [id_pkg::reg_addr_w-1:0] es_dest,
    output id_pkg::inst_t                 ds_inst,
    output logic [id_pkg::xlen-1:0]       ds_pc,
    output logic                          ds_valid,
    output logic                          blocked,
    output logic                          ds_allowin,
    output logic                          ds_to_es_valid
);

    // load result not ready until mem stage
    assign blocked = es_fwd_valid && es_load && es_dest != 5'd0 &&
                     ((rs_used && ds_inst.r_view.rs == es_dest) ||
                      (rt_used && ds_inst.r_view.rt == es_dest));

    assign ds_allowin     = !ds_valid || (!blocked && es_allowin);
    assign ds_to_es_valid = ds_valid && !blocked && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

endmodule

`default_nettype wire

/* files.f */
id_pkg.sv
regfile.sv
inst_decoder.sv
operand_forward.sv
branch_unit.sv
decode_ctrl.sv
id_stage.sv
tb_id_stage.sv

/* id_pkg.sv */
`default_nettype none

package id_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;
    localparam int br_op_w    = 6;

    // one-hot alu operation bits
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // conditional branch flags
    localparam int br_beq  = 0;
    localparam int br_bne  = 1;
    localparam int br_bgez = 2;
    localparam int br_bgtz = 3;
    localparam int br_blez = 4;
    localparam int br_bltz = 5;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    // regimm branches select on the rt field
    localparam logic [4:0] rt_bltz = 5'h00;
    localparam logic [4:0] rt_bgez = 5'h01;

    localparam logic [4:0] link_reg = 5'd31;

    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] sa;
            logic [5:0] func;
        } r_view;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } i_view;
        struct packed {
            logic [5:0]  op;
            logic [25:0] jidx26;
        } j_view;
    } inst_t;

endpackage

`default_nettype wire

/* id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          fs_to_ds_valid,
    input  id_pkg::inst_t                 fs_inst,
    input  logic [id_pkg::xlen-1:0]       fs_pc,
    input  logic                          es_allowin,
    input  logic                          flush,
    input  logic                          es_fwd_valid,
    input  logic                          es_load,
    input  logic [id_pkg::reg_addr_w-1:0] es_dest,
    input  logic [id_pkg::xlen-1:0]       es_res,
    input  logic                          ms_fwd_valid,
    input  logic [id_pkg::reg_addr_w-1:0] ms_dest,
    input  logic [id_pkg::xlen-1:0]       ms_res,
    input  logic                          ws_we,
    input  logic [id_pkg::reg_addr_w-1:0] ws_waddr,
    input  logic [id_pkg::xlen-1:0]       ws_wdata,
    output logic                          ds_allowin,
    output logic                          ds_to_es_valid,
    output logic [id_pkg::alu_op_w-1:0]   alu_op,
    output logic                          src1_is_sa,
    output logic                          src1_is_pc,
    output logic                          src2_is_imm,
    output logic                          src2_is_uimm,
    output logic                          src2_is_8,
    output logic                          load_op,
    output logic                          store_op,
    output logic                          gr_we,
    output logic [id_pkg::reg_addr_w-1:0] dest,
    output logic [15:0]                   imm,
    output logic [id_pkg::xlen-1:0]       rs_value,
    output logic [id_pkg::xlen-1:0]       rt_value,
    output logic [id_pkg::xlen-1:0]       ds_pc,
    output logic                          br_or_jump,
    output logic                          br_stall,
    output logic                          br_taken,
    output logic [id_pkg::xlen-1:0]       br_target
);
    import id_pkg::*;

    inst_t               ds_inst;
    logic                ds_valid;
    logic                blocked;
    logic                rs_used;
    logic                rt_used;
    logic [br_op_w-1:0]  branch_op;
    logic                jump_j;
    logic                jump_jal;
    logic                jump_jr;
    logic [xlen-1:0]     rdata1;
    logic [xlen-1:0]     rdata2;

    decode_ctrl u_ctrl (.*);

    inst_decoder u_dec (.*);

    regfile u_rf (
        .clk    (clk),
        .raddr1 (ds_inst.r_view.rs),
        .raddr2 (ds_inst.r_view.rt),
        .we     (ws_we),
        .waddr  (ws_waddr),
        .wdata  (ws_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    operand_forward u_fwd (
        .rs (ds_inst.r_view.rs),
        .rt (ds_inst.r_view.rt),
        .*
    );

    branch_unit u_br (
        .jidx (ds_inst.j_view.jidx26),
        .*
    );

endmodule

`default_nettype wire

/* inst_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module inst_decoder (
    input  id_pkg::inst_t                      ds_inst,
    output logic [id_pkg::alu_op_w-1:0]        alu_op,
    output logic                               src1_is_sa,
    output logic                               src1_is_pc,
    output logic                               src2_is_imm,
    output logic                               src2_is_uimm,
    output logic                               src2_is_8,
    output logic                               load_op,
    output logic                               store_op,
    output logic                               gr_we,
    output logic [id_pkg::reg_addr_w-1:0]      dest,
    output logic [15:0]                        imm,
    output logic                               rs_used,
    output logic                               rt_used,
    output logic [id_pkg::br_op_w-1:0]         branch_op,
    output logic                               jump_j,
    output logic                               jump_jal,
    output logic                               jump_jr
);
    import id_pkg::*;

    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    logic [5:0] func;
    logic       special;
    logic       r_alu;
    logic       inst_addu, inst_subu, inst_slt, inst_sltu;
    logic       inst_and, inst_or, inst_xor, inst_nor;
    logic       inst_sll, inst_srl, inst_sra, inst_jr;
    logic       inst_addiu, inst_slti, inst_sltiu, inst_andi;
    logic       inst_ori, inst_xori, inst_lui, inst_lw, inst_sw;
    logic       inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic       inst_j, inst_jal;
    logic       i_alu;
    logic       dst_is_rt;

    assign op   = ds_inst.r_view.op;
    assign rs   = ds_inst.r_view.rs;
    assign rt   = ds_inst.r_view.rt;
    assign rd   = ds_inst.r_view.rd;
    assign sa   = ds_inst.r_view.sa;
    assign func = ds_inst.r_view.func;
    assign imm  = ds_inst.i_view.imm16;

    assign special = (op == op_special);

    // three-register ops need sa clear
    assign inst_addu = special && func == fn_addu && sa == 5'd0;
    assign inst_subu = special && func == fn_subu && sa == 5'd0;
    assign inst_slt  = special && func == fn_slt  && sa == 5'd0;
    assign inst_sltu = special && func == fn_sltu && sa == 5'd0;
    assign inst_and  = special && func == fn_and  && sa == 5'd0;
    assign inst_or   = special && func == fn_or   && sa == 5'd0;
    assign inst_xor  = special && func == fn_xor  && sa == 5'd0;
    assign inst_nor  = special && func == fn_nor  && sa == 5'd0;
    // shifts by constant leave rs clear
    assign inst_sll  = special && func == fn_sll  && rs == 5'd0;
    assign inst_srl  = special && func == fn_srl  && rs == 5'd0;
    assign inst_sra  = special && func == fn_sra  && rs == 5'd0;
    assign inst_jr   = special && func == fn_jr   && rt == 5'd0 && rd == 5'd0 && sa == 5'd0;

    assign inst_addiu = (op == op_addiu);
    assign inst_slti  = (op == op_slti);
    assign inst_sltiu = (op == op_sltiu);
    assign inst_andi  = (op == op_andi);
    assign inst_ori   = (op == op_ori);
    assign inst_xori  = (op == op_xori);
    assign inst_lui   = (op == op_lui) && rs == 5'd0;
    assign inst_lw    = (op == op_lw);
    assign inst_sw    = (op == op_sw);

    assign inst_beq  = (op == op_beq);
    assign inst_bne  = (op == op_bne);
    assign inst_bgtz = (op == op_bgtz) && rt == 5'd0;
    assign inst_blez = (op == op_blez) && rt == 5'd0;
    assign inst_bgez = (op == op_regimm) && rt == rt_bgez;
    assign inst_bltz = (op == op_regimm) && rt == rt_bltz;
    assign inst_j    = (op == op_j);
    assign inst_jal  = (op == op_jal);

    assign r_alu = inst_addu | inst_subu | inst_slt | inst_sltu |
                   inst_and  | inst_or   | inst_xor | inst_nor;
    assign i_alu = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori | inst_xori;

    assign alu_op[alu_add]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
    assign alu_op[alu_sub]  = inst_subu;
    assign alu_op[alu_slt]  = inst_slt  | inst_slti;
    assign alu_op[alu_sltu] = inst_sltu | inst_sltiu;
    assign alu_op[alu_and]  = inst_and  | inst_andi;
    assign alu_op[alu_nor]  = inst_nor;
    assign alu_op[alu_or]   = inst_or   | inst_ori;
    assign alu_op[alu_xor]  = inst_xor  | inst_xori;
    assign alu_op[alu_sll]  = inst_sll;
    assign alu_op[alu_srl]  = inst_srl;
    assign alu_op[alu_sra]  = inst_sra;
    assign alu_op[alu_lui]  = inst_lui;

    assign src1_is_sa   = inst_sll | inst_srl | inst_sra;
    assign src1_is_pc   = inst_jal;
    assign src2_is_imm  = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
    assign src2_is_uimm = inst_andi | inst_ori | inst_xori;
    // jal writes pc + 8
    assign src2_is_8    = inst_jal;

    assign load_op  = inst_lw;
    assign store_op = inst_sw;

    assign branch_op[br_beq]  = inst_beq;
    assign branch_op[br_bne]  = inst_bne;
    assign branch_op[br_bgez] = inst_bgez;
    assign branch_op[br_bgtz] = inst_bgtz;
    assign branch_op[br_blez] = inst_blez;
    assign branch_op[br_bltz] = inst_bltz;
    assign jump_j   = inst_j;
    assign jump_jal = inst_jal;
    assign jump_jr  = inst_jr;

    assign dst_is_rt = i_alu | inst_lui | inst_lw;
    assign gr_we     = r_alu | src1_is_sa | dst_is_rt | inst_jal;
    assign dest      = inst_jal  ? link_reg :
                       dst_is_rt ? rt       :
                                   rd;

    assign rs_used = r_alu | i_alu | inst_lw | inst_sw | inst_jr | (|branch_op);
    assign rt_used = r_alu | src1_is_sa | inst_sw | inst_beq | inst_bne;

endmodule

`default_nettype wire

/* operand_forward.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_forward (
    input  logic [id_pkg::reg_addr_w-1:0] rs,
    input  logic [id_pkg::reg_addr_w-1:0] rt,
    input  logic                          rs_used,
    input  logic                          rt_used,
    input  logic [id_pkg::xlen-1:0]       rdata1,
    input  logic [id_pkg::xlen-1:0]       rdata2,
    input  logic                          es_fwd_valid,
    input  logic                          es_load,
    input  logic [id_pkg::reg_addr_w-1:0] es_dest,
    input  logic [id_pkg::xlen-1:0]       es_res,
    input  logic                          ms_fwd_valid,
    input  logic [id_pkg::reg_addr_w-1:0] ms_dest,
    input  logic [id_pkg::xlen-1:0]       ms_res,
    input  logic                          ws_we,
    input  logic [id_pkg::reg_addr_w-1:0] ws_waddr,
    input  logic [id_pkg::xlen-1:0]       ws_wdata,
    output logic [id_pkg::xlen-1:0]       rs_value,
    output logic [id_pkg::xlen-1:0]       rt_value
);
    import id_pkg::*;

    // youngest producer wins
    function automatic logic [xlen-1:0] pick(input logic [reg_addr_w-1:0] addr,
                                             input logic                  used,
                                             input logic [xlen-1:0]       rdata);
        if (!used || addr == '0) begin
            pick = rdata;
        end else if (es_fwd_valid && !es_load && es_dest == addr) begin
            pick = es_res;
        end else if (ms_fwd_valid && ms_dest == addr) begin
            pick = ms_res;
        end else if (ws_we && ws_waddr == addr) begin
            pick = ws_wdata;
        end else begin
            pick = rdata;
        end
    endfunction

    always_comb begin
        rs_value = pick(rs, rs_used, rdata1);
        rt_value = pick(rt, rt_used, rdata2);
    end

endmodule

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  logic                          clk,
    input  logic [id_pkg::reg_addr_w-1:0] raddr1,
    input  logic [id_pkg::reg_addr_w-1:0] raddr2,
    input  logic                          we,
    input  logic [id_pkg::reg_addr_w-1:0] waddr,
    input  logic [id_pkg::xlen-1:0]       wdata,
    output logic [id_pkg::xlen-1:0]       rdata1,
    output logic [id_pkg::xlen-1:0]       rdata2
);
    import id_pkg::*;

    logic [xlen-1:0] rf [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

/* tb_id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage;
    import id_pkg::*;

    localparam int n_rand     = 60;
    localparam int max_cycles = 3 + 31 * 2 + n_rand * 4 + 60;

    localparam logic [5:0] r_fn [8] = '{fn_addu, fn_subu, fn_slt, fn_sltu,
                                         fn_and, fn_or, fn_xor, fn_nor};
    localparam logic [5:0] sh_fn [3] = '{fn_sll, fn_srl, fn_sra};
    localparam logic [5:0] i_ops [15] = '{op_addiu, op_slti, op_sltiu, op_andi, op_ori,
                                           op_xori, op_lui, op_lw, op_sw, op_beq, op_bne,
                                           op_blez, op_bgtz, op_j, op_jal};

    typedef struct packed {
        logic [alu_op_w-1:0] alu_op;
        logic [4:0]          src;
        logic                gr_we;
        logic [4:0]          dest;
        logic                load;
        logic                store;
        logic                br;
        logic                taken;
        logic [31:0]         target;
    } exp_t;

    logic clk, reset, fs_to_ds_valid, es_allowin, flush;
    inst_t fs_inst;
    logic [xlen-1:0] fs_pc, es_res, ms_res, ws_wdata;
    logic es_fwd_valid, es_load, ms_fwd_valid, ws_we;
    logic [reg_addr_w-1:0] es_dest, ms_dest, ws_waddr;
    logic ds_allowin, ds_to_es_valid, src1_is_sa, src1_is_pc, src2_is_imm;
    logic src2_is_uimm, src2_is_8, load_op, store_op, gr_we;
    logic [alu_op_w-1:0] alu_op;
    logic [reg_addr_w-1:0] dest;
    logic [15:0] imm;
    logic [xlen-1:0] rs_value, rt_value, ds_pc, br_target;
    logic br_or_jump, br_stall, br_taken;

    logic [31:0] shadow [32];
    inst_t       cur_inst;
    logic [31:0] cur_pc, exp_rs, exp_rt;
    string       test_name;
    int          errors;

    id_stage DUT (.*);

    always #4 clk = ~clk;

    // expected decode from the MIPS encoding rules
    function automatic exp_t ref_decode(input inst_t i, input logic [31:0] pc,
                                        input logic [31:0] rsv, input logic [31:0] rtv);
        exp_t e;
        logic [31:0] slot;
        e = '0;
        slot = pc + 32'd4;
        e.target = slot + (32'($signed(i.i_view.imm16)) << 2);
        case (i.r_view.op)
            op_special: begin
                e.gr_we = 1'b1;
                e.dest = i.r_view.rd;
                case (i.r_view.func)
                    fn_addu: e.alu_op[alu_add] = 1'b1;
                    fn_subu: e.alu_op[alu_sub] = 1'b1;
                    fn_slt:  e.alu_op[alu_slt] = 1'b1;
                    fn_sltu: e.alu_op[alu_sltu] = 1'b1;
                    fn_and:  e.alu_op[alu_and] = 1'b1;
                    fn_or:   e.alu_op[alu_or] = 1'b1;
                    fn_xor:  e.alu_op[alu_xor] = 1'b1;
                    fn_nor:  e.alu_op[alu_nor] = 1'b1;
                    fn_sll:  e.alu_op[alu_sll] = 1'b1;
                    fn_srl:  e.alu_op[alu_srl] = 1'b1;
                    fn_sra:  e.alu_op[alu_sra] = 1'b1;
                    fn_jr: begin
                        e.gr_we = 1'b0;
                        e.br = 1'b1;
                        e.taken = 1'b1;
                        e.target = rsv;
                    end
                    default: e.gr_we = 1'b0;
                endcase
                e.src[4] = e.alu_op[alu_sll] | e.alu_op[alu_srl] | e.alu_op[alu_sra];
            end
            op_addiu, op_slti, op_sltiu, op_lui, op_lw: begin
                e.gr_we = 1'b1;
                e.dest = i.i_view.rt;
                e.src[2] = 1'b1;
                e.load = (i.r_view.op == op_lw);
                e.alu_op[alu_add]  = (i.r_view.op == op_addiu) || (i.r_view.op == op_lw);
                e.alu_op[alu_slt]  = (i.r_view.op == op_slti);
                e.alu_op[alu_sltu] = (i.r_view.op == op_sltiu);
                e.alu_op[alu_lui]  = (i.r_view.op == op_lui);
            end
            op_andi, op_ori, op_xori: begin
                e.gr_we = 1'b1;
                e.dest = i.i_view.rt;
                e.src[1] = 1'b1;
                e.alu_op[alu_and] = (i.r_view.op == op_andi);
                e.alu_op[alu_or]  = (i.r_view.op == op_ori);
                e.alu_op[alu_xor] = (i.r_view.op == op_xori);
            end
            op_sw: begin
                e.src[2] = 1'b1;
                e.store = 1'b1;
                e.alu_op[alu_add] = 1'b1;
            end
            op_beq, op_bne, op_blez, op_bgtz, op_regimm: begin
                e.br = 1'b1;
                case (i.r_view.op)
                    op_beq:  e.taken = (rsv == rtv);
                    op_bne:  e.taken = (rsv != rtv);
                    op_blez: e.taken = ($signed(rsv) <= 0);
                    op_bgtz: e.taken = ($signed(rsv) > 0);
                    default: e.taken = (i.r_view.rt == rt_bgez) ? ($signed(rsv) >= 0)
                                                                : ($signed(rsv) < 0);
                endcase
            end
            op_j, op_jal: begin
                e.br = 1'b1;
                e.taken = 1'b1;
                e.target = (slot & 32'hf000_0000) | (32'(i.j_view.jidx26) << 2);
                if (i.r_view.op == op_jal) begin
                    e.gr_we = 1'b1;
                    e.dest = link_reg;
                    e.alu_op[alu_add] = 1'b1;
                    e.src[3] = 1'b1;
                    e.src[0] = 1'b1;
                end
            end
            default: e = '0;
        endcase
        return e;
    endfunction

    function automatic inst_t rand_inst();
        inst_t i;
        int kind;
        i = $urandom;
        kind = $urandom_range(0, 29);
        if ($urandom_range(0, 7) == 0) begin
            i.r_view.rs = 5'd0;
        end
        if (kind < 12) begin
            i.r_view.op = op_special;
            if (kind < 8) begin
                i.r_view.sa = 5'd0;
                i.r_view.func = r_fn[kind];
            end else if (kind < 11) begin
                i.r_view.rs = 5'd0;
                i.r_view.func = sh_fn[kind-8];
            end else begin
                i.r_view.func = fn_jr;
                i.r_view.rt = 5'd0;
                i.r_view.rd = 5'd0;
                i.r_view.sa = 5'd0;
            end
        end else if (kind < 27) begin
            i.r_view.op = i_ops[kind-12];
            if (i.r_view.op == op_lui) i.r_view.rs = 5'd0;
            if (i.r_view.op == op_blez || i.r_view.op == op_bgtz) i.r_view.rt = 5'd0;
            if ((i.r_view.op == op_beq || i.r_view.op == op_bne) && $urandom_range(0, 3) == 0) begin
                i.r_view.rt = i.r_view.rs;
            end
        end else if (kind < 29) begin
            i.r_view.op = op_regimm;
            i.r_view.rt = (kind == 27) ? rt_bltz : rt_bgez;
        end else begin
            // opcode outside the kept set
            i.r_view.op = 6'h3f;
        end
        return i;
    endfunction

    task automatic check_val(input string field, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            errors++;
            $display("[ERROR] %s %s: expected %h actual %h", test_name, field, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("%s: %s", test_name, what);
        end
    endtask

    always @(negedge clk) begin : compare
        exp_t e;
        if (!reset && (ds_to_es_valid || br_or_jump)) begin
            e = ref_decode(cur_inst, cur_pc, exp_rs, exp_rt);
            check_val("alu_op", 32'(e.alu_op), 32'(alu_op));
            check_val("src flags", 32'(e.src), 32'({src1_is_sa, src1_is_pc, src2_is_imm,
                                                    src2_is_uimm, src2_is_8}));
            check_val("gr_we", 32'(e.gr_we), 32'(gr_we));
            if (e.gr_we) check_val("dest", 32'(e.dest), 32'(dest));
            check_val("load_op", 32'(e.load), 32'(load_op));
            check_val("store_op", 32'(e.store), 32'(store_op));
            check_val("imm", 32'(cur_inst.i_view.imm16), 32'(imm));
            check_val("rs_value", exp_rs, rs_value);
            check_val("rt_value", exp_rt, rt_value);
            check_val("ds_pc", cur_pc, ds_pc);
            check_val("br_or_jump", 32'(e.br), 32'(br_or_jump));
            if (e.br) begin
                check_val("br_taken", 32'(e.taken && !flush), 32'(br_taken));
                check_val("br_target", e.target, br_target);
            end
        end
    end

    task automatic wb_write(input logic [4:0] addr, input logic [31:0] data);
        ws_we = 1'b1;
        ws_waddr = addr;
        ws_wdata = data;
        @(posedge clk);
        #1;
        ws_we = 1'b0;
        if (addr != 5'd0) shadow[addr] = data;
    endtask

    // returns one ns after the transfer edge
    task automatic accept_inst(input inst_t i, input logic [31:0] pc);
        cur_inst = i;
        cur_pc = pc;
        exp_rs = shadow[i.r_view.rs];
        exp_rt = shadow[i.r_view.rt];
        fs_inst = i;
        fs_pc = pc;
        fs_to_ds_valid = 1'b1;
        do @(negedge clk); while (!ds_allowin);
        @(posedge clk);
        #1;
        fs_to_ds_valid = 1'b0;
    endtask

    task automatic wait_issue();
        do @(negedge clk); while (!(ds_to_es_valid && es_allowin));
        @(posedge clk);
        #1;
    endtask

    function automatic inst_t make_r(input logic [5:0] op, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [5:0] func);
        inst_t i;
        i = '0;
        i.r_view.op = op;
        i.r_view.rs = rs;
        i.r_view.rt = rt;
        i.r_view.rd = 5'd3;
        i.r_view.func = func;
        return i;
    endfunction

    initial begin
        void'($urandom(32'h80f5_49cd));
        errors = 0;
        clk = 1'b0;
        reset = 1'b1;
        {fs_to_ds_valid, flush, es_fwd_valid, es_load, ms_fwd_valid, ws_we} = '0;
        es_allowin = 1'b1;
        fs_inst = '0;
        {fs_pc, es_res, ms_res, ws_wdata} = '0;
        {es_dest, ms_dest, ws_waddr} = '0;
        for (int r = 0; r < 32; r++) shadow[r] = '0;
        cur_inst = '0;
        {cur_pc, exp_rs, exp_rt} = '0;
        test_name = "reset";
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_true(ds_allowin && !ds_to_es_valid && !br_taken && !br_stall,
                   "stage not idle after reset");
        @(posedge clk);
        #1;

        test_name = "regfile init";
        for (int r = 1; r < 32; r++) wb_write(5'(r), $urandom);

        test_name = "random decode";
        for (int n = 0; n < n_rand; n++) begin
            accept_inst(rand_inst(), $urandom & 32'hffff_fffc);
            wait_issue();
        end

        test_name = "same cycle writeback";
        es_allowin = 1'b0;
        accept_inst(make_r(op_special, 5'd5, 5'd6, fn_addu), 32'h0000_1000);
        ws_we = 1'b1;
        ws_waddr = 5'd5;
        ws_wdata = $urandom;
        exp_rs = ws_wdata;
        @(posedge clk);
        #1;
        ws_we = 1'b0;
        shadow[5] = ws_wdata;
        @(posedge clk);
        #1;
        es_allowin = 1'b1;
        wait_issue();

        test_name = "register zero";
        es_allowin = 1'b0;
        accept_inst(make_r(op_special, 5'd0, 5'd0, fn_or), 32'h0000_1010);
        {es_fwd_valid, ms_fwd_valid, ws_we} = 3'b111;
        {es_dest, ms_dest, ws_waddr} = '0;
        es_res = $urandom;
        ms_res = $urandom;
        ws_wdata = $urandom;
        @(posedge clk);
        #1;
        {es_fwd_valid, ms_fwd_valid, ws_we} = 3'b000;
        es_allowin = 1'b1;
        wait_issue();

        test_name = "forward priority";
        es_allowin = 1'b0;
        {es_fwd_valid, ms_fwd_valid, ws_we} = 3'b111;
        {es_dest, ms_dest, ws_waddr} = {3{5'd7}};
        accept_inst(make_r(op_special, 5'd7, 5'd0, fn_addu), 32'h0000_1020);
        exp_rs = es_res;
        @(posedge clk);
        #1;
        es_fwd_valid = 1'b0;
        exp_rs = ms_res;
        @(posedge clk);
        #1;
        ms_fwd_valid = 1'b0;
        exp_rs = ws_wdata;
        @(posedge clk);
        #1;
        ws_we = 1'b0;
        shadow[7] = ws_wdata;
        es_allowin = 1'b1;
        wait_issue();

        test_name = "load use block";
        es_fwd_valid = 1'b1;
        es_load = 1'b1;
        es_dest = 5'd9;
        accept_inst(make_r(op_beq, 5'd9, 5'd10, 6'h04), 32'h0000_2000);
        repeat (3) begin
            @(negedge clk);
            check_true(!ds_to_es_valid, "ds_to_es_valid high during load block");
            check_true(!ds_allowin, "ds_allowin high during load block");
            check_true(br_stall, "br_stall low during load block");
        end
        @(posedge clk);
        #1;
        {es_fwd_valid, es_load} = 2'b00;
        ms_fwd_valid = 1'b1;
        ms_dest = 5'd9;
        ms_res = shadow[10];
        exp_rs = ms_res;
        wait_issue();
        ms_fwd_valid = 1'b0;

        test_name = "backpressure and flush";
        es_allowin = 1'b0;
        accept_inst(make_r(op_j, 5'd1, 5'd2, 6'h11), 32'h1234_5670);
        fs_inst = rand_inst();
        fs_pc = 32'h0000_3000;
        fs_to_ds_valid = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_true(!ds_allowin, "ds_allowin high under backpressure");
            check_true(ds_pc == cur_pc, "held instruction replaced under backpressure");
        end
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(negedge clk);
        check_true(!ds_to_es_valid && !br_taken, "flush did not mask outputs");
        @(posedge clk);
        #1;
        flush = 1'b0;
        fs_to_ds_valid = 1'b0;
        es_allowin = 1'b1;
        wait_issue();

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(max_cycles * 8 + 200);
        $display("watchdog timeout, run did not finish within %0d cycles", max_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
